// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_irq_subsys
FILELIST = src.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer
    import soc_irq_pkg::*;
#(
    parameter int CPU_NUM = 2
)
(
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  logic                i_wr,
    input  logic                i_rd,
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [DATA_W-1:0]   i_wdata,
    output logic [DATA_W-1:0]   o_rdata,
    output logic                o_rhit,
    output logic [CPU_NUM-1:0]  o_msip,
    output logic [CPU_NUM-1:0]  o_mtip,
    output logic [63:0]         o_mtimer
);

logic [63:0] mtime;
logic [CPU_NUM-1:0][63:0] mtimecmp;
logic [CPU_NUM-1:0] msip;
logic [CPU_NUM-1:0] mtip_c;
logic wr_sel;
logic rd_sel;
logic [DATA_W-1:0] rdata_c;
logic [DATA_W-1:0] rdata_q;
logic rhit_q;

assign wr_sel = i_wr && (i_addr < PLIC_WINDOW);
assign rd_sel = i_rd && (i_addr < PLIC_WINDOW);

always_ff @(posedge i_sys_clk)
begin: regs_proc
    if (!i_rst_n)
    begin
        mtime <= '0;
        msip <= '0;
        mtimecmp <= '1;                         // Timer interrupt stays off until programmed
    end
    else
    begin
        mtime <= mtime + 64'd1;
        if (wr_sel)
        begin
            for (int h = 0; h < CPU_NUM; h++)
            begin
                if (i_addr == CLINT_MSIP_BASE + ADDR_W'(h))
                    msip[h] <= i_wdata[0];
                if (i_addr == CLINT_CMP_BASE + ADDR_W'(2 * h))
                    mtimecmp[h][31:0] <= i_wdata;
                if (i_addr == CLINT_CMP_BASE + ADDR_W'(2 * h + 1))
                    mtimecmp[h][63:32] <= i_wdata;
            end
        end
    end
end: regs_proc

always_comb
begin: mtip_proc
    for (int h = 0; h < CPU_NUM; h++)
        mtip_c[h] = (mtime >= mtimecmp[h]);
end: mtip_proc

// Unmapped words in the window read zero
always_comb
begin: rd_mux_proc
    rdata_c = '0;
    if (i_addr == CLINT_MTIME_LO)
        rdata_c = mtime[31:0];
    if (i_addr == CLINT_MTIME_HI)
        rdata_c = mtime[63:32];
    for (int h = 0; h < CPU_NUM; h++)
    begin
        if (i_addr == CLINT_MSIP_BASE + ADDR_W'(h))
            rdata_c = DATA_W'(msip[h]);
        if (i_addr == CLINT_CMP_BASE + ADDR_W'(2 * h))
            rdata_c = mtimecmp[h][31:0];
        if (i_addr == CLINT_CMP_BASE + ADDR_W'(2 * h + 1))
            rdata_c = mtimecmp[h][63:32];
    end
end: rd_mux_proc

always_ff @(posedge i_sys_clk)
begin: rd_proc
    if (!i_rst_n)
        rhit_q <= 1'b0;
    else
        rhit_q <= rd_sel;
    if (rd_sel)
        rdata_q <= rdata_c;
end: rd_proc

assign o_rdata = rdata_q;
assign o_rhit = rhit_q;
assign o_msip = msip;
assign o_mtip = mtip_c;
assign o_mtimer = mtime;

a_rhit_after_rd: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    $rose(o_rhit) |-> $past(i_rd));

endmodule: clint_timer

`default_nettype wire

// ==== hw/hart_irq_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module hart_irq_map
    import soc_irq_pkg::*;
#(
    parameter int CPU_NUM = 2
)
(
    input  logic                    i_sys_clk,
    input  logic                    i_rst_n,
    input  logic [DATA_W-1:0]       i_clint_rdata,
    input  logic                    i_clint_rhit,
    input  logic [DATA_W-1:0]       i_plic_rdata,
    input  logic                    i_plic_rhit,
    input  logic [CPU_NUM-1:0]      i_msip,
    input  logic [CPU_NUM-1:0]      i_mtip,
    input  logic [2*CPU_NUM-2:0]    i_ctx_ip,
    output logic [DATA_W-1:0]       o_rdata,
    output logic                    o_rvalid,
    output logic [CPU_NUM-1:0]      o_msip,
    output logic [CPU_NUM-1:0]      o_mtip,
    output logic [CPU_NUM-1:0]      o_meip,
    output logic [CPU_NUM-1:0]      o_seip
);

logic [CPU_NUM-1:0] meip_c;
logic [CPU_NUM-1:0] seip_c;
logic [DATA_W-1:0] rdata_c;

// Context 0 is hart 0 machine, then machine and supervisor pairs per hart
always_comb
begin: map_proc
    meip_c = '0;
    seip_c = '0;                                // Hart 0 is machine mode only
    meip_c[0] = i_ctx_ip[0];
    for (int h = 1; h < CPU_NUM; h++)
    begin
        meip_c[h] = i_ctx_ip[2 * h - 1];
        seip_c[h] = i_ctx_ip[2 * h];
    end
end: map_proc

assign rdata_c = i_clint_rhit ? i_clint_rdata :
                 i_plic_rhit  ? i_plic_rdata  : '0;

always_ff @(posedge i_sys_clk)
begin: lines_proc
    if (!i_rst_n)
    begin
        o_rvalid <= 1'b0;
        o_msip <= '0;
        o_mtip <= '0;
        o_meip <= '0;
        o_seip <= '0;
    end
    else
    begin
        o_rvalid <= i_clint_rhit | i_plic_rhit;
        o_msip <= i_msip;
        o_mtip <= i_mtip;
        o_meip <= meip_c;
        o_seip <= seip_c;
    end
    o_rdata <= rdata_c;
end: lines_proc

// Address windows of the two units do not overlap
a_single_hit: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    !(i_clint_rhit && i_plic_rhit));

endmodule: hart_irq_map

`default_nettype wire

// ==== hw/irq_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_subsys
    import soc_irq_pkg::*;
#(
    parameter int CPU_NUM = 2,
    parameter int IRQ_TOTAL = 8                 // Includes reserved source 0
)
(
    input  logic                    i_sys_clk,  // System clock
    input  logic                    i_rst_n,
    input  logic                    i_wr,
    input  logic                    i_rd,
    input  logic [ADDR_W-1:0]       i_addr,
    input  logic [DATA_W-1:0]       i_wdata,
    input  logic [IRQ_TOTAL-1:0]    i_irq,
    output logic [DATA_W-1:0]       o_rdata,
    output logic                    o_rvalid,
    output logic [CPU_NUM-1:0]      o_msip,
    output logic [CPU_NUM-1:0]      o_mtip,
    output logic [CPU_NUM-1:0]      o_meip,
    output logic [CPU_NUM-1:0]      o_seip
);

logic [DATA_W-1:0] wb_clint_rdata;
logic w_clint_rhit;
logic [CPU_NUM-1:0] wb_clint_msip;
logic [CPU_NUM-1:0] wb_clint_mtip;
logic [DATA_W-1:0] wb_plic_rdata;
logic w_plic_rhit;
logic [2*CPU_NUM-2:0] wb_plic_ip;               // One bit per context

clint_timer #(
    .CPU_NUM(CPU_NUM)
) clint0 (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_wr(i_wr),
    .i_rd(i_rd),
    .i_addr(i_addr),
    .i_wdata(i_wdata),
    .o_rdata(wb_clint_rdata),
    .o_rhit(w_clint_rhit),
    .o_msip(wb_clint_msip),
    .o_mtip(wb_clint_mtip),
    .o_mtimer()
);

plic_core #(
    .CPU_NUM(CPU_NUM),
    .IRQ_TOTAL(IRQ_TOTAL)
) plic0 (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_wr(i_wr),
    .i_rd(i_rd),
    .i_addr(i_addr),
    .i_wdata(i_wdata),
    .i_irq(i_irq),
    .o_rdata(wb_plic_rdata),
    .o_rhit(w_plic_rhit),
    .o_ip(wb_plic_ip)
);

hart_irq_map #(
    .CPU_NUM(CPU_NUM)
) map0 (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_clint_rdata(wb_clint_rdata),
    .i_clint_rhit(w_clint_rhit),
    .i_plic_rdata(wb_plic_rdata),
    .i_plic_rhit(w_plic_rhit),
    .i_msip(wb_clint_msip),
    .i_mtip(wb_clint_mtip),
    .i_ctx_ip(wb_plic_ip),
    .o_rdata(o_rdata),
    .o_rvalid(o_rvalid),
    .o_msip(o_msip),
    .o_mtip(o_mtip),
    .o_meip(o_meip),
    .o_seip(o_seip)
);

endmodule: irq_subsys

`default_nettype wire

// ==== hw/plic_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module plic_core
    import soc_irq_pkg::*;
#(
    parameter int CPU_NUM = 2,
    parameter int IRQ_TOTAL = 8
)
(
    input  logic                    i_sys_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wr,
    input  logic                    i_rd,
    input  logic [ADDR_W-1:0]       i_addr,
    input  logic [DATA_W-1:0]       i_wdata,
    input  logic [IRQ_TOTAL-1:0]    i_irq,
    output logic [DATA_W-1:0]       o_rdata,
    output logic                    o_rhit,
    output logic [2*CPU_NUM-2:0]    o_ip
);

localparam int CTX_NUM = 2 * CPU_NUM - 1;       // Hart 0 has no supervisor context
localparam int ID_W = $clog2(IRQ_TOTAL);
localparam logic [IRQ_TOTAL-1:0] SRC_MASK = {{(IRQ_TOTAL - 1){1'b1}}, 1'b0};

logic wr_sel;
logic rd_sel;
logic [IRQ_TOTAL-1:0] irq_q;
logic [IRQ_TOTAL-1:0] irq_rise;
logic [IRQ_TOTAL-1:0] pending;
logic [IRQ_TOTAL-1:0] in_svc_any;
logic [IRQ_TOTAL-1:0] claim_clr;
plic_prio_word_t prio_q;
logic [CTX_NUM-1:0][IRQ_TOTAL-1:0] enable;
logic [CTX_NUM-1:0][PRIO_W-1:0] thresh;
logic [CTX_NUM-1:0][IRQ_TOTAL-1:0] in_svc;
logic [CTX_NUM-1:0][IRQ_TOTAL-1:0] claim_oh;
logic [CTX_NUM-1:0][IRQ_TOTAL-1:0] cmpl_oh;
logic [CTX_NUM-1:0][PRIO_W-1:0] best_prio;
logic [CTX_NUM-1:0][ID_W-1:0] best_id;
logic [CTX_NUM-1:0] claim_hit;
logic [CTX_NUM-1:0] ctx_ip;
logic [DATA_W-1:0] rdata_c;
logic [DATA_W-1:0] rdata_q;
logic rhit_q;

assign wr_sel = i_wr && (i_addr >= PLIC_WINDOW);
assign rd_sel = i_rd && (i_addr >= PLIC_WINDOW);
assign irq_rise = i_irq & ~irq_q;

// Strict compare keeps the lowest id on ties
always_comb
begin: arb_proc
    for (int c = 0; c < CTX_NUM; c++)
    begin
        best_id[c] = '0;
        best_prio[c] = '0;                      // Priority 0 can never win
        for (int s = 1; s < IRQ_TOTAL; s++)
        begin
            if (pending[s] && enable[c][s] && (prio_q.prio[s] > best_prio[c]))
            begin
                best_id[c] = ID_W'(s);
                best_prio[c] = prio_q.prio[s];
            end
        end
        ctx_ip[c] = (best_prio[c] > thresh[c]);
    end
end: arb_proc

always_comb
begin: claim_proc
    claim_clr = '0;
    in_svc_any = '0;
    for (int c = 0; c < CTX_NUM; c++)
    begin
        claim_hit[c] = rd_sel && (i_addr == PLIC_CLAIM_BASE + ADDR_W'(c));
        claim_oh[c] = '0;
        cmpl_oh[c] = '0;
        for (int s = 1; s < IRQ_TOTAL; s++)
        begin
            if (claim_hit[c] && (best_id[c] == ID_W'(s)))
                claim_oh[c][s] = 1'b1;
            // Complete is a write of the id to the claim word
            if (wr_sel && (i_addr == PLIC_CLAIM_BASE + ADDR_W'(c))
                    && (i_wdata == DATA_W'(s)))
                cmpl_oh[c][s] = 1'b1;
        end
        claim_clr = claim_clr | claim_oh[c];
        in_svc_any = in_svc_any | in_svc[c];
    end
end: claim_proc

always_ff @(posedge i_sys_clk)
begin: gateway_proc
    if (!i_rst_n)
    begin
        irq_q <= '0;
        pending <= '0;
        in_svc <= '0;
    end
    else
    begin
        irq_q <= i_irq;
        // Claim wins over a new edge in the same cycle
        pending <= (pending | (irq_rise & ~in_svc_any)) & ~claim_clr & SRC_MASK;
        for (int c = 0; c < CTX_NUM; c++)
            in_svc[c] <= (in_svc[c] | claim_oh[c]) & ~cmpl_oh[c];
    end
end: gateway_proc

always_ff @(posedge i_sys_clk)
begin: cfg_proc
    if (!i_rst_n)
    begin
        prio_q <= '0;
        enable <= '0;
        thresh <= '0;
    end
    else if (wr_sel)
    begin
        if (i_addr == PLIC_PRIO)
            prio_q.raw <= i_wdata;
        for (int c = 0; c < CTX_NUM; c++)
        begin
            if (i_addr == PLIC_ENABLE_BASE + ADDR_W'(c))
                enable[c] <= i_wdata[IRQ_TOTAL-1:0];
            if (i_addr == PLIC_THRESH_BASE + ADDR_W'(c))
                thresh[c] <= i_wdata[PRIO_W-1:0];
        end
    end
end: cfg_proc

always_comb
begin: rd_mux_proc
    rdata_c = '0;
    if (i_addr == PLIC_PRIO)
        rdata_c = prio_q.raw;
    if (i_addr == PLIC_PENDING)
        rdata_c = DATA_W'(pending);
    for (int c = 0; c < CTX_NUM; c++)
    begin
        if (i_addr == PLIC_ENABLE_BASE + ADDR_W'(c))
            rdata_c = DATA_W'(enable[c]);
        if (i_addr == PLIC_THRESH_BASE + ADDR_W'(c))
            rdata_c = DATA_W'(thresh[c]);
        if (claim_hit[c])
            rdata_c = DATA_W'(best_id[c]);      // Zero when nothing eligible
    end
end: rd_mux_proc

always_ff @(posedge i_sys_clk)
begin: rd_proc
    if (!i_rst_n)
        rhit_q <= 1'b0;
    else
        rhit_q <= rd_sel;
    if (rd_sel)
        rdata_q <= rdata_c;
end: rd_proc

assign o_rdata = rdata_q;
assign o_rhit = rhit_q;
assign o_ip = ctx_ip;

a_claim_id_range: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    (|claim_hit) |=> (o_rdata < DATA_W'(IRQ_TOTAL)));

// Source 0 is reserved and never pending
a_src0_never_pending: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    !pending[0]);

endmodule: plic_core

`default_nettype wire

// ==== hw/soc_irq_pkg.sv ====
`default_nettype none

package soc_irq_pkg;

    localparam int DATA_W = 32;                 // Register data width
    localparam int ADDR_W = 8;                  // Word address width
    localparam int PRIO_W = 4;                  // One source priority
    localparam int SRC_MAX = 8;                 // Sources held by one priority word

    // CLINT window, all below PLIC_WINDOW
    localparam logic [ADDR_W-1:0] CLINT_MSIP_BASE = 8'h00;   // Plus hart index
    localparam logic [ADDR_W-1:0] CLINT_CMP_BASE = 8'h08;    // Two words per hart, low first
    localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 8'h1E;
    localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 8'h1F;

    // PLIC window
    localparam logic [ADDR_W-1:0] PLIC_WINDOW = 8'h40;
    localparam logic [ADDR_W-1:0] PLIC_PRIO = 8'h40;
    localparam logic [ADDR_W-1:0] PLIC_PENDING = 8'h41;      // Read only
    localparam logic [ADDR_W-1:0] PLIC_ENABLE_BASE = 8'h48;  // Plus context index
    localparam logic [ADDR_W-1:0] PLIC_THRESH_BASE = 8'h50;  // Plus context index
    localparam logic [ADDR_W-1:0] PLIC_CLAIM_BASE = 8'h58;   // Plus context index

    // Priority register seen as a bus word or per source
    typedef union packed {
        logic [DATA_W-1:0] raw;
        logic [SRC_MAX-1:0][PRIO_W-1:0] prio;   // Indexed by source id
    } plic_prio_word_t;

endpackage: soc_irq_pkg

`default_nettype wire

// ==== sim/tb_irq_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_irq_subsys
    import soc_irq_pkg::*;
;

localparam int CPU_NUM = 2;
localparam int IRQ_TOTAL = 8;
localparam int CTX_NUM = 2 * CPU_NUM - 1;
localparam int RD_TIMEOUT = 8;                  // Cycles allowed for a read response
localparam int MTIP_TIMEOUT = 200;

logic i_sys_clk = 1'b0;
logic i_rst_n;
logic i_wr;
logic i_rd;
logic [ADDR_W-1:0] i_addr;
logic [DATA_W-1:0] i_wdata;
logic [IRQ_TOTAL-1:0] i_irq;
logic [DATA_W-1:0] o_rdata;
logic o_rvalid;
logic [CPU_NUM-1:0] o_msip;
logic [CPU_NUM-1:0] o_mtip;
logic [CPU_NUM-1:0] o_meip;
logic [CPU_NUM-1:0] o_seip;

// Reference state of the controller
logic [DATA_W-1:0] prio_w;
logic [CTX_NUM-1:0][IRQ_TOTAL-1:0] en_m;
logic [CTX_NUM-1:0][PRIO_W-1:0] th_m;
logic [IRQ_TOTAL-1:0] pend_m;
logic [IRQ_TOTAL-1:0] svc_m;

irq_subsys #(
    .CPU_NUM(CPU_NUM),
    .IRQ_TOTAL(IRQ_TOTAL)
) dut0 (
    .i_sys_clk(i_sys_clk),
    .i_rst_n(i_rst_n),
    .i_wr(i_wr),
    .i_rd(i_rd),
    .i_addr(i_addr),
    .i_wdata(i_wdata),
    .i_irq(i_irq),
    .o_rdata(o_rdata),
    .o_rvalid(o_rvalid),
    .o_msip(o_msip),
    .o_mtip(o_mtip),
    .o_meip(o_meip),
    .o_seip(o_seip)
);

always #20 i_sys_clk = ~i_sys_clk;

task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic check_word(input string name, input logic [DATA_W-1:0] exp_v,
                          input logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v)
        stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp_v, act_v));
endtask

task automatic check_lines(input string name, input logic [CPU_NUM-1:0] exp_v,
                           input logic [CPU_NUM-1:0] act_v);
    if (act_v !== exp_v)
        stop_run($sformatf("ERR %s: expected %b, actual %b", name, exp_v, act_v));
endtask

task automatic next_cycle();
    @(posedge i_sys_clk);
    #1;                                         // Drive and sample clear of the edge
endtask

task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    i_wr = 1'b1;
    i_addr = addr;
    i_wdata = data;
    next_cycle();
    i_wr = 1'b0;
endtask

task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic got;
    int n;
    i_rd = 1'b1;
    i_addr = addr;
    next_cycle();
    i_rd = 1'b0;
    got = 1'b0;
    for (n = 0; n < RD_TIMEOUT && !got; n++)
    begin
        next_cycle();
        got = o_rvalid;
    end
    if (!got)
        stop_run($sformatf("No read response for address %h", addr));
    data = o_rdata;
endtask

task automatic check_read(input string name, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] exp_v);
    logic [DATA_W-1:0] val;
    reg_read(addr, val);
    check_word(name, exp_v, val);
endtask

// Highest priority among pending, enabled sources of a context
function automatic int top_prio(input int c);
    int top;
    top = 0;
    for (int s = 1; s < IRQ_TOTAL; s++)
        if (pend_m[s] && en_m[c][s] && int'(prio_w[PRIO_W*s +: PRIO_W]) > top)
            top = int'(prio_w[PRIO_W*s +: PRIO_W]);
    return top;
endfunction

function automatic int claim_id(input int c);
    int top;
    top = top_prio(c);
    if (top == 0)
        return 0;
    for (int s = 1; s < IRQ_TOTAL; s++)       // Lowest id with that priority
        if (pend_m[s] && en_m[c][s] && int'(prio_w[PRIO_W*s +: PRIO_W]) == top)
            return s;
    return 0;
endfunction

function automatic logic ctx_on(input int c);
    return top_prio(c) > int'(th_m[c]);
endfunction

task automatic check_irq_lines(input string name);
    logic [CPU_NUM-1:0] meip;
    logic [CPU_NUM-1:0] seip;
    meip = '0;
    seip = '0;
    meip[0] = ctx_on(0);
    for (int h = 1; h < CPU_NUM; h++)
    begin
        meip[h] = ctx_on(2 * h - 1);
        seip[h] = ctx_on(2 * h);
    end
    next_cycle();                               // Hart lines trail the state by a cycle
    check_lines({name, "_meip"}, meip, o_meip);
    check_lines({name, "_seip"}, seip, o_seip);
endtask

task automatic set_prio(input logic [DATA_W-1:0] w);
    prio_w = w;
    reg_write(PLIC_PRIO, w);
endtask

task automatic set_enable(input int c, input logic [IRQ_TOTAL-1:0] m);
    en_m[c] = m;
    reg_write(PLIC_ENABLE_BASE + ADDR_W'(c), DATA_W'(m));
endtask

task automatic set_thresh(input int c, input logic [PRIO_W-1:0] t);
    th_m[c] = t;
    reg_write(PLIC_THRESH_BASE + ADDR_W'(c), DATA_W'(t));
endtask

task automatic pulse_irq(input logic [IRQ_TOTAL-1:0] mask);
    i_irq = mask;
    next_cycle();
    i_irq = '0;
    next_cycle();                               // Let the edge detector see the low
    pend_m = pend_m | (mask & ~svc_m & ~IRQ_TOTAL'(1));
endtask

task automatic claim_once(input int c, input string name, output int id);
    logic [DATA_W-1:0] val;
    id = claim_id(c);
    reg_read(PLIC_CLAIM_BASE + ADDR_W'(c), val);
    check_word(name, DATA_W'(id), val);
    if (id != 0)
    begin
        pend_m[id] = 1'b0;
        svc_m[id] = 1'b1;
    end
endtask

task automatic complete(input int c, input int id);
    reg_write(PLIC_CLAIM_BASE + ADDR_W'(c), DATA_W'(id));
    svc_m[id] = 1'b0;
endtask

// Equal priorities on all sources, then claim and complete until nothing is left
task automatic drain_pending();
    int id;
    set_prio(32'h1111_1110);
    set_enable(0, 8'hFE);
    set_thresh(0, 4'd0);
    for (int n = 0; n < IRQ_TOTAL; n++)
    begin
        claim_once(0, "drain_claim", id);
        if (id == 0)
            break;
        complete(0, id);
    end
    check_read("drain_pending", PLIC_PENDING, DATA_W'(pend_m));
endtask

task automatic test_reset();
    check_lines("reset_msip", '0, o_msip);
    check_lines("reset_mtip", '0, o_mtip);
    check_lines("reset_meip", '0, o_meip);
    check_lines("reset_seip", '0, o_seip);
    if (o_rvalid !== 1'b0)
        stop_run("o_rvalid is high after reset");
    check_read("reset_cmp", CLINT_CMP_BASE, 32'hFFFF_FFFF);
    check_read("reset_enable", PLIC_ENABLE_BASE, 32'd0);
endtask

task automatic test_msip();
    logic [CPU_NUM-1:0] want;
    for (int h = 0; h < CPU_NUM; h++)
    begin
        want = '0;
        want[h] = 1'b1;
        reg_write(CLINT_MSIP_BASE + ADDR_W'(h), 32'd1);
        next_cycle();
        check_lines("msip_set", want, o_msip);
        check_read("msip_readback", CLINT_MSIP_BASE + ADDR_W'(h), 32'd1);
        reg_write(CLINT_MSIP_BASE + ADDR_W'(h), 32'd0);
        next_cycle();
        check_lines("msip_clear", '0, o_msip);
        check_read("msip_cleared", CLINT_MSIP_BASE + ADDR_W'(h), 32'd0);
    end
endtask

task automatic test_timer();
    logic [DATA_W-1:0] t_hi;
    logic [DATA_W-1:0] t_lo;
    logic risen;
    reg_read(CLINT_MTIME_HI, t_hi);
    reg_read(CLINT_MTIME_LO, t_lo);
    reg_write(CLINT_CMP_BASE + ADDR_W'(2), t_lo + 32'd30);  // Hart 1 low word goes first
    reg_write(CLINT_CMP_BASE + ADDR_W'(3), t_hi);
    next_cycle();
    check_lines("mtip_early", '0, o_mtip);
    risen = 1'b0;
    for (int n = 0; n < MTIP_TIMEOUT && !risen; n++)
    begin
        next_cycle();
        if (o_mtip[0])
            stop_run("Hart 0 timer interrupt raised without a compare match");
        risen = o_mtip[1];
    end
    if (!risen)
        stop_run("Hart 1 timer interrupt did not rise in time");
    reg_write(CLINT_CMP_BASE + ADDR_W'(3), 32'hFFFF_FFFF);
    reg_write(CLINT_CMP_BASE + ADDR_W'(2), 32'hFFFF_FFFF);
    next_cycle();
    check_lines("mtip_off", '0, o_mtip);
endtask

task automatic test_routing();
    set_prio($urandom);
    check_read("prio_readback", PLIC_PRIO, prio_w);
    for (int c = 0; c < CTX_NUM; c++)
    begin
        set_enable(c, IRQ_TOTAL'($urandom));
        set_thresh(c, PRIO_W'($urandom % 4));
        check_read("enable_readback", PLIC_ENABLE_BASE + ADDR_W'(c), DATA_W'(en_m[c]));
        check_read("thresh_readback", PLIC_THRESH_BASE + ADDR_W'(c), DATA_W'(th_m[c]));
    end
    for (int k = 0; k < 6; k++)
    begin
        pulse_irq(IRQ_TOTAL'(1) << ($urandom % IRQ_TOTAL));
        check_irq_lines("route");
        check_read("route_pending", PLIC_PENDING, DATA_W'(pend_m));
    end
endtask

task automatic test_claim();
    int id;
    drain_pending();
    set_prio(32'h3071_5520);                    // Source 6 has priority 0
    set_enable(1, 8'hFE);
    set_thresh(1, 4'd0);
    pulse_irq(8'hFE);
    check_irq_lines("claim_lines");
    check_read("claim_pending", PLIC_PENDING, DATA_W'(pend_m));
    claim_once(1, "claim_first", id);
    pulse_irq(IRQ_TOTAL'(1) << id);             // In service, so not latched
    check_read("in_service_pending", PLIC_PENDING, DATA_W'(pend_m));
    complete(1, id);
    pulse_irq(IRQ_TOTAL'(1) << id);
    check_read("completed_pending", PLIC_PENDING, DATA_W'(pend_m));
    for (int n = 0; n < IRQ_TOTAL + 1; n++)
    begin
        claim_once(1, "claim_order", id);
        check_read("claim_order_pending", PLIC_PENDING, DATA_W'(pend_m));
        check_irq_lines("claim_order");
        if (id == 0)
            break;
    end
    for (int s = 1; s < IRQ_TOTAL; s++)
        if (svc_m[s])
            complete(1, s);
endtask

task automatic test_threshold();
    int id;
    drain_pending();
    set_prio(32'h0000_6400);                    // Source 2 at 4, source 3 at 6
    set_enable(0, 8'h4C);
    set_enable(1, 8'h00);
    set_enable(2, 8'h40);                       // Only the zero-priority source
    set_thresh(2, 4'd0);
    pulse_irq(8'h4C);
    check_irq_lines("thresh_low");
    set_thresh(0, 4'd6);
    check_irq_lines("thresh_top");
    set_thresh(0, 4'd5);
    check_irq_lines("thresh_below_top");
    claim_once(2, "zero_prio_claim", id);
    check_irq_lines("zero_prio");
    claim_once(0, "thresh_claim", id);
    complete(0, id);
    check_irq_lines("thresh_done");
endtask

initial
begin: main_seq
    i_rst_n = 1'b0;
    i_wr = 1'b0;
    i_rd = 1'b0;
    i_addr = '0;
    i_wdata = '0;
    i_irq = '0;
    prio_w = '0;
    en_m = '0;
    th_m = '0;
    pend_m = '0;
    svc_m = '0;
    void'($urandom(32'ha7fc_635b));
    repeat (4) @(posedge i_sys_clk);
    #1;
    i_rst_n = 1'b1;
    next_cycle();
    test_reset();
    test_msip();
    test_timer();
    test_routing();
    test_claim();
    test_threshold();
    $display("No errors");
    $finish;
end: main_seq

endmodule: tb_irq_subsys

`default_nettype wire

// ==== src.f ====
hw/soc_irq_pkg.sv
hw/clint_timer.sv
hw/plic_core.sv
hw/hart_irq_map.sv
hw/irq_subsys.sv
sim/tb_irq_subsys.sv
